//--- hw/glb_pkg.sv
// data-path sizes and processor packet types for the global buffer tile
// shared by the bank, the stream DMA, the tile top and the testbench
// a processor packet carries a kind plus a 24-bit payload; the payload
// is one word read either as a write or as a read request
package glb_pkg;

    // bank and stream word width
    localparam int DATA_WIDTH = 16;

    // 8 address bits, so 256 words in the single bank
    localparam int BANK_ADDR_WIDTH = 8;
    localparam int BANK_DEPTH = 1 << BANK_ADDR_WIDTH;

    localparam int PKT_KIND_WIDTH = 2;

    // packet kinds seen on the processor port
    typedef enum logic [PKT_KIND_WIDTH-1:0] {
        PKT_NONE = 2'd0,
        PKT_WR   = 2'd1,
        PKT_RDRQ = 2'd2
    } pkt_kind_t;

    // write payload, address then data
    typedef struct packed {
        logic [BANK_ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0]      data;
    } wr_payload_t;

    // read request, address in the same place as a write
    typedef struct packed {
        logic [BANK_ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0]      pad;
    } rdrq_payload_t;

    // same 24 bits, decoded by packet kind
    typedef union packed {
        wr_payload_t   wr;
        rdrq_payload_t rdrq;
    } pkt_payload_t;

    typedef struct packed {
        pkt_kind_t    kind;
        pkt_payload_t payload;
    } packet_t;

    // read response back to the processor
    typedef struct packed {
        logic                  valid;
        logic [DATA_WIDTH-1:0] data;
    } rd_packet_t;

endpackage

//--- hw/glb_cfg_pkg.sv
// configuration register map and stream DMA header for the tile
// used by the configuration register file, the stream DMA, the tile top
// and the testbench
package glb_cfg_pkg;

    localparam int CFG_ADDR_WIDTH = 2;
    localparam int CFG_DATA_WIDTH = 16;

    // register addresses, address 3 reads as zero
    localparam logic [CFG_ADDR_WIDTH-1:0] CFG_REG_MODE  = 2'd0;
    localparam logic [CFG_ADDR_WIDTH-1:0] CFG_REG_START = 2'd1;
    localparam logic [CFG_ADDR_WIDTH-1:0] CFG_REG_NUM   = 2'd2;

    // header field widths; num goes up to 256 words
    localparam int DMA_MODE_WIDTH  = 2;
    localparam int DMA_START_WIDTH = 8;
    localparam int DMA_NUM_WIDTH   = 9;

    typedef enum logic [DMA_MODE_WIDTH-1:0] {
        DMA_OFF   = 2'd0,
        DMA_STORE = 2'd1,
        DMA_LOAD  = 2'd2
    } dma_mode_t;

    typedef struct packed {
        dma_mode_t                  mode;
        logic [DMA_START_WIDTH-1:0] start_addr;
        logic [DMA_NUM_WIDTH-1:0]   num_words;
    } dma_header_t;

    typedef struct packed {
        logic                      wr_en;
        logic                      rd_en;
        logic [CFG_ADDR_WIDTH-1:0] addr;
        logic [CFG_DATA_WIDTH-1:0] wr_data;
    } cfg_req_t;

endpackage

//--- hw/glb_tile_cfg.sv
// configuration register file of the tile
// holds the one stream DMA header as mode, start and num registers
// writes land at the clock edge, reads come back one cycle later
// the decoded header drives the stream DMA at all times
`timescale 1ns/1ps

module glb_tile_cfg import glb_cfg_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,
    input  cfg_req_t                  cfg_req,
    output logic [CFG_DATA_WIDTH-1:0] cfg_rd_data,
    output logic                      cfg_rd_valid,
    output dma_header_t               dma_header
);

    dma_mode_t                  mode_r;
    logic [DMA_START_WIDTH-1:0] start_r;
    logic [DMA_NUM_WIDTH-1:0]   num_r;

    // read-back mux, zero-extended to register width
    logic [CFG_DATA_WIDTH-1:0]  rd_mux;

    // register writes
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mode_r  <= DMA_OFF;
            start_r <= '0;
            num_r   <= '0;
        end else if (cfg_req.wr_en) begin
            // upper write bits just drop off
            case (cfg_req.addr)
                CFG_REG_MODE: begin
                    mode_r <= dma_mode_t'(cfg_req.wr_data[DMA_MODE_WIDTH-1:0]);
                end
                CFG_REG_START: begin
                    start_r <= cfg_req.wr_data[DMA_START_WIDTH-1:0];
                end
                CFG_REG_NUM: begin
                    num_r <= cfg_req.wr_data[DMA_NUM_WIDTH-1:0];
                end
                default: begin
                    // address 3 has no register
                end
            endcase
        end
    end

    always_comb begin
        case (cfg_req.addr)
            CFG_REG_MODE:  rd_mux = CFG_DATA_WIDTH'(mode_r);
            CFG_REG_START: rd_mux = CFG_DATA_WIDTH'(start_r);
            CFG_REG_NUM:   rd_mux = CFG_DATA_WIDTH'(num_r);
            default:       rd_mux = '0;
        endcase
    end

    // read valid strobe, one cycle after the request
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg_rd_valid <= 1'b0;
        end else begin
            cfg_rd_valid <= cfg_req.rd_en;
        end
    end

    // read data only moves on a read
    always_ff @(posedge clk) begin
        if (cfg_req.rd_en) begin
            cfg_rd_data <= rd_mux;
        end
    end

    // header as the DMA sees it
    assign dma_header.mode       = mode_r;
    assign dma_header.start_addr = start_r;
    assign dma_header.num_words  = num_r;

endmodule

//--- hw/glb_bank.sv
// single memory bank of the tile, 256 words of 16 bits
// processor side takes one packet per cycle, write or read request,
// and answers a read with a valid response one cycle later
// DMA side gets a plain write strobe and a read strobe on a shared address
// everything freezes while clk_en is low
`timescale 1ns/1ps

module glb_bank import glb_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       clk_en,
    input  packet_t                    proc_packet,
    output rd_packet_t                 proc_rd_packet,
    input  logic                       dma_wr_en,
    input  logic                       dma_rd_en,
    input  logic [BANK_ADDR_WIDTH-1:0] dma_addr,
    input  logic [DATA_WIDTH-1:0]      dma_wr_data,
    output logic [DATA_WIDTH-1:0]      dma_rd_data
);

    logic [DATA_WIDTH-1:0]      mem [BANK_DEPTH];

    // decoded processor packet
    logic                       pkt_wr;
    logic                       pkt_rd;
    logic [BANK_ADDR_WIDTH-1:0] pkt_wr_addr;
    logic [BANK_ADDR_WIDTH-1:0] pkt_rd_addr;
    logic [DATA_WIDTH-1:0]      pkt_wr_data;

    // processor response registers
    logic                       rd_valid_q;
    logic [DATA_WIDTH-1:0]      rd_data_q;

    // kind picks how the payload union is read
    always_comb begin
        pkt_wr      = (proc_packet.kind == PKT_WR);
        pkt_rd      = (proc_packet.kind == PKT_RDRQ);
        pkt_wr_addr = proc_packet.payload.wr.addr;
        pkt_wr_data = proc_packet.payload.wr.data;
        pkt_rd_addr = proc_packet.payload.rdrq.addr;
    end

    // write port
    // DMA and processor never overlap, DMA first just in case
    always_ff @(posedge clk) begin
        if (clk_en) begin
            if (dma_wr_en) begin
                mem[dma_addr] <= dma_wr_data;
            end else if (pkt_wr) begin
                mem[pkt_wr_addr] <= pkt_wr_data;
            end
        end
    end

    // registered read data, both ports
    always_ff @(posedge clk) begin
        if (clk_en) begin
            if (pkt_rd) begin
                rd_data_q <= mem[pkt_rd_addr];
            end
            if (dma_rd_en) begin
                dma_rd_data <= mem[dma_addr];
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_valid_q <= 1'b0;
        end else if (clk_en) begin
            rd_valid_q <= pkt_rd;
        end
    end

    // held response stays hidden during stall so it is seen only once
    assign proc_rd_packet.valid = rd_valid_q & clk_en;
    assign proc_rd_packet.data  = rd_data_q;

endmodule

//--- hw/glb_strm_dma.sv
// stream DMA between the fabric streams and the bank
// store mode writes each f2g word to start + count,
// load mode reads start .. start + num - 1 and sends it out on g2f
// a registered start pulse kicks it off using the header mode;
// pulses while busy, or with mode off or num zero, are dropped
// done pulses go to the tile top, which turns them into interrupts
`timescale 1ns/1ps

module glb_strm_dma import glb_pkg::*, glb_cfg_pkg::*; (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       clk_en,
    input  logic                       start_pulse,
    input  dma_header_t                dma_header,
    input  logic [DATA_WIDTH-1:0]      stream_data_f2g,
    input  logic                       stream_valid_f2g,
    output logic [DATA_WIDTH-1:0]      stream_data_g2f,
    output logic                       stream_valid_g2f,
    output logic                       dma_wr_en,
    output logic                       dma_rd_en,
    output logic [BANK_ADDR_WIDTH-1:0] dma_addr,
    output logic [DATA_WIDTH-1:0]      dma_wr_data,
    input  logic [DATA_WIDTH-1:0]      dma_rd_data,
    output logic                       store_done_pulse,
    output logic                       load_done_pulse
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_STORE,
        ST_LOAD
    } state_t;

    state_t                     state;

    // header copy taken at start
    logic [DMA_START_WIDTH-1:0] start_q;
    logic [DMA_NUM_WIDTH-1:0]   num_q;

    // words written, or reads issued
    logic [DMA_NUM_WIDTH-1:0]   cnt;

    logic                       start_ok;
    logic                       last;
    logic                       wr_fire;
    logic                       rd_fire;

    // one-cycle pipeline lining up with the bank read latency
    logic                       rd_vld_q;
    logic                       rd_last_q;

    // accept start only from idle, with a real mode and at least one word
    assign start_ok = clk_en && start_pulse && (state == ST_IDLE)
                      && (dma_header.num_words != '0)
                      && ((dma_header.mode == DMA_STORE) || (dma_header.mode == DMA_LOAD));

    assign last    = (cnt == num_q - DMA_NUM_WIDTH'(1));
    assign wr_fire = clk_en && (state == ST_STORE) && stream_valid_f2g;
    // load reads one address per enabled cycle
    assign rd_fire = clk_en && (state == ST_LOAD);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= ST_IDLE;
            cnt   <= '0;
        end else if (start_ok) begin
            state <= (dma_header.mode == DMA_STORE) ? ST_STORE : ST_LOAD;
            cnt   <= '0;
        end else if (wr_fire || rd_fire) begin
            cnt <= cnt + DMA_NUM_WIDTH'(1);
            if (last) begin
                state <= ST_IDLE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start_ok) begin
            start_q <= dma_header.start_addr;
            num_q   <= dma_header.num_words;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_vld_q  <= 1'b0;
            rd_last_q <= 1'b0;
        end else if (clk_en) begin
            rd_vld_q  <= rd_fire;
            rd_last_q <= rd_fire && last;
        end
    end

    // bank side, address wraps past 255
    assign dma_wr_en   = wr_fire;
    assign dma_rd_en   = rd_fire;
    assign dma_addr    = start_q + cnt[BANK_ADDR_WIDTH-1:0];
    assign dma_wr_data = stream_data_f2g;

    // g2f word held during stall, shown once clk_en is back
    assign stream_data_g2f  = dma_rd_data;
    assign stream_valid_g2f = rd_vld_q && clk_en;

    // store done with the last write, load done with the last g2f word
    assign store_done_pulse = wr_fire && last;
    assign load_done_pulse  = rd_vld_q && rd_last_q && clk_en;

endmodule

//--- hw/glb_tile.sv
// global buffer tile reduced to one bank and one stream DMA
// processor packets go straight to the bank and config requests to the
// register file, while the DMA moves the f2g and g2f streams
// stall, start and the interrupts each pass through one register here
// so cgra_stall and the interrupts show up one cycle after their cause
`timescale 1ns/1ps

module glb_tile import glb_pkg::*, glb_cfg_pkg::*; (
    input  logic                      clk,
    input  logic                      reset,

    // stall in and its registered copy out to the fabric
    input  logic                      stall,
    output logic                      cgra_stall,

    // processor packet port
    input  packet_t                   proc_packet,
    output rd_packet_t                proc_rd_packet,

    // configuration
    input  cfg_req_t                  cfg_req,
    output logic [CFG_DATA_WIDTH-1:0] cfg_rd_data,
    output logic                      cfg_rd_valid,

    // stream DMA trigger and streams
    input  logic                      strm_start_pulse,
    input  logic [DATA_WIDTH-1:0]     stream_data_f2g,
    input  logic                      stream_valid_f2g,
    output logic [DATA_WIDTH-1:0]     stream_data_g2f,
    output logic                      stream_valid_g2f,

    // interrupts
    output logic                      strm_f2g_interrupt_pulse,
    output logic                      strm_g2f_interrupt_pulse
);

    // registered stall and start
    logic                       stall_d1;
    logic                       start_d1;
    logic                       clk_en;

    // done strobes from the DMA, one cycle before the interrupts
    logic                       store_done_pulse;
    logic                       load_done_pulse;

    // header from the register file to the DMA
    dma_header_t                dma_header;

    // DMA port of the bank
    logic                       dma_wr_en;
    logic                       dma_rd_en;
    logic [BANK_ADDR_WIDTH-1:0] dma_addr;
    logic [DATA_WIDTH-1:0]      dma_wr_data;
    logic [DATA_WIDTH-1:0]      dma_rd_data;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            stall_d1                 <= 1'b0;
            start_d1                 <= 1'b0;
            strm_f2g_interrupt_pulse <= 1'b0;
            strm_g2f_interrupt_pulse <= 1'b0;
        end else begin
            stall_d1                 <= stall;
            start_d1                 <= strm_start_pulse;
            strm_f2g_interrupt_pulse <= store_done_pulse;
            strm_g2f_interrupt_pulse <= load_done_pulse;
        end
    end

    assign cgra_stall = stall_d1;
    // bank and DMA only advance while the fabric runs
    assign clk_en     = ~stall_d1;

    glb_tile_cfg u_cfg (
        .clk          (clk),
        .reset        (reset),
        .cfg_req      (cfg_req),
        .cfg_rd_data  (cfg_rd_data),
        .cfg_rd_valid (cfg_rd_valid),
        .dma_header   (dma_header)
    );

    glb_bank u_bank (
        .clk            (clk),
        .reset          (reset),
        .clk_en         (clk_en),
        .proc_packet    (proc_packet),
        .proc_rd_packet (proc_rd_packet),
        .dma_wr_en      (dma_wr_en),
        .dma_rd_en      (dma_rd_en),
        .dma_addr       (dma_addr),
        .dma_wr_data    (dma_wr_data),
        .dma_rd_data    (dma_rd_data)
    );

    glb_strm_dma u_dma (
        .clk              (clk),
        .reset            (reset),
        .clk_en           (clk_en),
        .start_pulse      (start_d1),
        .dma_header       (dma_header),
        .stream_data_f2g  (stream_data_f2g),
        .stream_valid_f2g (stream_valid_f2g),
        .stream_data_g2f  (stream_data_g2f),
        .stream_valid_g2f (stream_valid_g2f),
        .dma_wr_en        (dma_wr_en),
        .dma_rd_en        (dma_rd_en),
        .dma_addr         (dma_addr),
        .dma_wr_data      (dma_wr_data),
        .dma_rd_data      (dma_rd_data),
        .store_done_pulse (store_done_pulse),
        .load_done_pulse  (load_done_pulse)
    );

endmodule

//--- tests/glb_tile_tb.sv
// testbench for the global buffer tile
// directed tests cover reset state, config registers, processor access,
// f2g store, g2f load and stall during a load
// a reference array models the bank and a negedge monitor collects g2f words
`timescale 1ns/1ps

module glb_tile_tb import glb_pkg::*, glb_cfg_pkg::*; ();

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 4;
    localparam logic [31:0] SEED = 32'h0f258c10;
    localparam int NUM_PROC     = 24;
    localparam int STORE_WORDS  = 40;
    localparam int LOAD_WORDS   = 48;
    localparam int STALL_WORDS  = 36;
    localparam int STALL_CYCLES = 5;
    // rough cycle cost of each test plus margin
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + 2 * BANK_DEPTH + 60 + 6 * NUM_PROC
                                     + 6 * STORE_WORDS + 5 * LOAD_WORDS
                                     + 5 * STALL_WORDS + STALL_CYCLES + 400;

    logic                      clk;
    logic                      reset;
    logic                      stall;
    logic                      cgra_stall;
    packet_t                   proc_packet;
    rd_packet_t                proc_rd_packet;
    cfg_req_t                  cfg_req;
    logic [CFG_DATA_WIDTH-1:0] cfg_rd_data;
    logic                      cfg_rd_valid;
    logic                      strm_start_pulse;
    logic [DATA_WIDTH-1:0]     stream_data_f2g;
    logic                      stream_valid_f2g;
    logic [DATA_WIDTH-1:0]     stream_data_g2f;
    logic                      stream_valid_g2f;
    logic                      strm_f2g_interrupt_pulse;
    logic                      strm_g2f_interrupt_pulse;

    // bank model
    logic [DATA_WIDTH-1:0]     ref_mem [BANK_DEPTH];

    // monitor state
    logic [DATA_WIDTH-1:0]     g2f_words [$];
    int                        cyc_cnt;
    int                        last_word_cyc;
    int                        g2f_irq_cnt;
    int                        g2f_irq_cyc;
    int                        f2g_irq_cnt;

    glb_tile dut0 (
        .clk                      (clk),
        .reset                    (reset),
        .stall                    (stall),
        .cgra_stall               (cgra_stall),
        .proc_packet              (proc_packet),
        .proc_rd_packet           (proc_rd_packet),
        .cfg_req                  (cfg_req),
        .cfg_rd_data              (cfg_rd_data),
        .cfg_rd_valid             (cfg_rd_valid),
        .strm_start_pulse         (strm_start_pulse),
        .stream_data_f2g          (stream_data_f2g),
        .stream_valid_f2g         (stream_valid_f2g),
        .stream_data_g2f          (stream_data_g2f),
        .stream_valid_g2f         (stream_valid_g2f),
        .strm_f2g_interrupt_pulse (strm_f2g_interrupt_pulse),
        .strm_g2f_interrupt_pulse (strm_g2f_interrupt_pulse)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        stop_run();
    end

    task automatic stop_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic fail_now(input string why);
        $display("%s", why);
        stop_run();
    endtask

    task automatic compare_rd_packet(input string name, input rd_packet_t got,
                                     input rd_packet_t exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic compare_cfg(input string name, input logic [CFG_DATA_WIDTH-1:0] got,
                               input logic [CFG_DATA_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic compare_stream(input string name, input logic [DATA_WIDTH-1:0] got,
                                  input logic [DATA_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got=%h exp=%h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got=%b exp=%b", $time, name, got, exp);
            stop_run();
        end
    endtask

    // pattern over the whole address so no two words alias
    function automatic logic [DATA_WIDTH-1:0] fill_word(input logic [7:0] a);
        return {a ^ 8'h5a, ~a} + 16'h1357;
    endfunction

    function automatic logic [CFG_DATA_WIDTH-1:0] mask_to_width(
        input logic [CFG_DATA_WIDTH-1:0] v, input int width);
        return v & ((CFG_DATA_WIDTH'(1) << width) - CFG_DATA_WIDTH'(1));
    endfunction

    // samples g2f words and interrupts mid-cycle and flags a word during stall
    always @(negedge clk) begin
        if (!reset) begin
            cyc_cnt++;
            if (stream_valid_g2f === 1'b1) begin
                if (cgra_stall === 1'b1) begin
                    fail_now("g2f word appeared while cgra_stall was high");
                end
                g2f_words.push_back(stream_data_g2f);
                last_word_cyc = cyc_cnt;
            end
            if (strm_g2f_interrupt_pulse === 1'b1) begin
                g2f_irq_cnt++;
                g2f_irq_cyc = cyc_cnt;
            end
            if (strm_f2g_interrupt_pulse === 1'b1) begin
                f2g_irq_cnt++;
            end
        end
    end

    task automatic clear_monitor();
        g2f_words.delete();
        g2f_irq_cnt = 0;
        f2g_irq_cnt = 0;
    endtask

    task automatic proc_write(input logic [7:0] addr, input logic [DATA_WIDTH-1:0] data);
        packet_t p;
        p.kind            = PKT_WR;
        p.payload.wr.addr = addr;
        p.payload.wr.data = data;
        @(posedge clk);
        proc_packet <= p;
        ref_mem[addr] = data;
    endtask

    task automatic proc_idle();
        @(posedge clk);
        proc_packet <= '0;
    endtask

    // response must show exactly one cycle after the request
    task automatic proc_read_check(input logic [7:0] addr);
        packet_t    p;
        rd_packet_t exp;
        p.kind              = PKT_RDRQ;
        p.payload.rdrq.addr = addr;
        p.payload.rdrq.pad  = '0;
        exp.valid           = 1'b1;
        exp.data            = ref_mem[addr];
        @(posedge clk);
        proc_packet <= p;
        @(negedge clk);
        compare_bit("proc_rd_packet.valid", proc_rd_packet.valid, 1'b0);
        @(posedge clk);
        proc_packet <= '0;
        @(negedge clk);
        compare_rd_packet("proc_rd_packet", proc_rd_packet, exp);
    endtask

    task automatic cfg_write(input logic [CFG_ADDR_WIDTH-1:0] addr,
                             input logic [CFG_DATA_WIDTH-1:0] data);
        cfg_req_t r;
        r.wr_en   = 1'b1;
        r.rd_en   = 1'b0;
        r.addr    = addr;
        r.wr_data = data;
        @(posedge clk);
        cfg_req <= r;
        @(posedge clk);
        cfg_req <= '0;
    endtask

    task automatic cfg_read_check(input logic [CFG_ADDR_WIDTH-1:0] addr,
                                  input logic [CFG_DATA_WIDTH-1:0] exp);
        cfg_req_t r;
        r.wr_en   = 1'b0;
        r.rd_en   = 1'b1;
        r.addr    = addr;
        r.wr_data = '0;
        @(posedge clk);
        cfg_req <= r;
        @(negedge clk);
        compare_bit("cfg_rd_valid", cfg_rd_valid, 1'b0);
        @(posedge clk);
        cfg_req <= '0;
        @(negedge clk);
        compare_bit("cfg_rd_valid", cfg_rd_valid, 1'b1);
        compare_cfg("cfg_rd_data", cfg_rd_data, exp);
    endtask

    task automatic setup_dma(input dma_mode_t mode, input logic [7:0] start, input int n);
        cfg_write(CFG_REG_MODE, CFG_DATA_WIDTH'(mode));
        cfg_write(CFG_REG_START, CFG_DATA_WIDTH'(start));
        cfg_write(CFG_REG_NUM, CFG_DATA_WIDTH'(n));
        clear_monitor();
        @(posedge clk);
        strm_start_pulse <= 1'b1;
        @(posedge clk);
        strm_start_pulse <= 1'b0;
    endtask

    task automatic test_reset_state();
        @(negedge clk);
        compare_bit("proc_rd_packet.valid", proc_rd_packet.valid, 1'b0);
        compare_bit("cfg_rd_valid", cfg_rd_valid, 1'b0);
        compare_bit("stream_valid_g2f", stream_valid_g2f, 1'b0);
        compare_bit("strm_f2g_interrupt_pulse", strm_f2g_interrupt_pulse, 1'b0);
        compare_bit("strm_g2f_interrupt_pulse", strm_g2f_interrupt_pulse, 1'b0);
        compare_bit("cgra_stall", cgra_stall, 1'b0);
        cfg_read_check(CFG_REG_MODE, '0);
        cfg_read_check(CFG_REG_START, '0);
        cfg_read_check(CFG_REG_NUM, '0);
    endtask

    task automatic test_config();
        // upper bits beyond each field must read back as zero
        cfg_write(CFG_REG_MODE, 16'hfff6);
        cfg_write(CFG_REG_START, 16'hab3c);
        cfg_write(CFG_REG_NUM, 16'hff05);
        cfg_read_check(CFG_REG_MODE, mask_to_width(16'hfff6, DMA_MODE_WIDTH));
        cfg_read_check(CFG_REG_START, mask_to_width(16'hab3c, DMA_START_WIDTH));
        cfg_read_check(CFG_REG_NUM, mask_to_width(16'hff05, DMA_NUM_WIDTH));
        cfg_read_check(2'd3, '0);
        cfg_write(CFG_REG_MODE, CFG_DATA_WIDTH'(DMA_OFF));
        cfg_read_check(CFG_REG_MODE, '0);
    endtask

    task automatic test_proc_access();
        logic [7:0] wr_addrs [NUM_PROC];
        for (int i = 0; i < NUM_PROC; i++) begin
            wr_addrs[i] = 8'($urandom);
            proc_write(wr_addrs[i], DATA_WIDTH'($urandom));
        end
        proc_idle();
        for (int i = 0; i < NUM_PROC; i++) begin
            proc_read_check(wr_addrs[i]);
        end
        // other addresses keep their modelled value
        for (int i = 0; i < 8; i++) begin
            proc_read_check(8'($urandom));
        end
    endtask

    task automatic test_store(input logic [7:0] start, input int n);
        logic [DATA_WIDTH-1:0] word;
        setup_dma(DMA_STORE, start, n);
        @(posedge clk);
        for (int i = 0; i < n; i++) begin
            if ($urandom % 4 == 0) begin
                @(posedge clk);
                stream_valid_f2g <= 1'b0;
            end
            word = DATA_WIDTH'($urandom);
            @(posedge clk);
            stream_data_f2g  <= word;
            stream_valid_f2g <= 1'b1;
            ref_mem[start + 8'(i)] = word;
        end
        @(negedge clk);
        compare_bit("strm_f2g_interrupt_pulse", strm_f2g_interrupt_pulse, 1'b0);
        @(posedge clk);
        stream_valid_f2g <= 1'b0;
        @(negedge clk);
        compare_bit("strm_f2g_interrupt_pulse", strm_f2g_interrupt_pulse, 1'b1);
        @(negedge clk);
        compare_bit("strm_f2g_interrupt_pulse", strm_f2g_interrupt_pulse, 1'b0);
        if (f2g_irq_cnt != 1) begin
            fail_now($sformatf("store raised %0d f2g interrupts instead of one", f2g_irq_cnt));
        end
        for (int i = 0; i < n; i++) begin
            proc_read_check(start + 8'(i));
        end
    endtask

    // stall shows on cgra_stall one cycle after each change
    task automatic apply_stall();
        @(posedge clk);
        stall <= 1'b1;
        @(negedge clk);
        compare_bit("cgra_stall", cgra_stall, 1'b0);
        @(negedge clk);
        compare_bit("cgra_stall", cgra_stall, 1'b1);
        repeat (STALL_CYCLES) @(posedge clk);
        stall <= 1'b0;
        @(negedge clk);
        compare_bit("cgra_stall", cgra_stall, 1'b1);
        @(negedge clk);
        compare_bit("cgra_stall", cgra_stall, 1'b0);
    endtask

    // stall_after of zero runs the load without a stall
    task automatic run_load(input logic [7:0] start, input int n, input int stall_after);
        int waited;
        for (int i = 0; i < n; i++) begin
            proc_write(start + 8'(i), DATA_WIDTH'($urandom));
        end
        proc_idle();
        setup_dma(DMA_LOAD, start, n);
        waited = 0;
        while (stall_after > 0 && g2f_words.size() < stall_after) begin
            @(posedge clk);
            waited++;
            if (waited > n + 20) begin
                fail_now("load never reached the word where stall is applied");
            end
        end
        if (stall_after > 0) begin
            apply_stall();
        end
        waited = 0;
        while (g2f_irq_cnt == 0) begin
            @(negedge clk);
            waited++;
            if (waited > n + 40) begin
                fail_now("load did not raise strm_g2f_interrupt_pulse");
            end
        end
        repeat (3) @(negedge clk);
        if (g2f_words.size() != n) begin
            fail_now($sformatf("load sent %0d g2f words, expected %0d", g2f_words.size(), n));
        end
        for (int i = 0; i < n; i++) begin
            compare_stream("stream_data_g2f", g2f_words[i], ref_mem[start + 8'(i)]);
        end
        if (g2f_irq_cnt != 1 || g2f_irq_cyc != last_word_cyc + 1) begin
            fail_now("g2f interrupt was not one pulse one cycle after the last word");
        end
    endtask

    initial begin
        void'($urandom(SEED));
        reset            = 1'b1;
        stall            = 1'b0;
        proc_packet      = '0;
        cfg_req          = '0;
        strm_start_pulse = 1'b0;
        stream_data_f2g  = '0;
        stream_valid_f2g = 1'b0;
        cyc_cnt          = 0;
        last_word_cyc    = 0;
        g2f_irq_cyc      = 0;
        clear_monitor();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        test_reset_state();
        // every bank word starts from a known pattern
        for (int a = 0; a < BANK_DEPTH; a++) begin
            proc_write(8'(a), fill_word(8'(a)));
        end
        proc_idle();
        test_config();
        test_proc_access();
        test_store(8'hf0, STORE_WORDS);
        run_load(8'h10, LOAD_WORDS, 0);
        run_load(8'he8, STALL_WORDS, STALL_WORDS / 3);
        repeat (4) @(posedge clk);
        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- build.f
hw/glb_pkg.sv
hw/glb_cfg_pkg.sv
hw/glb_tile_cfg.sv
hw/glb_bank.sv
hw/glb_strm_dma.sv
hw/glb_tile.sv
tests/glb_tile_tb.sv

//--- Makefile
# Verilator build and run for the global buffer tile testbench
# override any variable on the command line, e.g. make run TOP=glb_tile_tb

VERILATOR ?= verilator
TOP       ?= glb_tile_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the pass line shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
